// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mem_axi_bridge_tb
FILELIST  = mem_axi_bridge.f
OBJ_DIR   = obj_dir
PASS_MSG  = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// File: include/mem_axi_params.svh
`ifndef MEM_AXI_PARAMS_SVH
`define MEM_AXI_PARAMS_SVH

// Bus widths
`define MEM_AXI_ADDR_WIDTH 32
`define MEM_AXI_LINE_WIDTH 128   // One cache line per beat
`define MEM_AXI_STRB_WIDTH 16    // One bit per line byte
`define MEM_AXI_ID_WIDTH   4

// Transaction IDs
`define MEM_AXI_INST_ID 0        // Instruction refill
`define MEM_AXI_DATA_ID 1        // Data refill and all writes

// Fixed AXI field codes
`define MEM_AXI_SIZE_LINE  4     // 16 bytes per beat
`define MEM_AXI_BURST_INCR 1

`endif

// File: mem_axi_bridge.f
+incdir+include
source/mem_axi_pkg.sv
source/axi_read_master.sv
source/axi_write_master.sv
source/mem_axi_bridge.sv
testbench/mem_axi_bridge_checker.sv
testbench/mem_axi_bridge_tb.sv

// File: source/axi_read_master.sv
`default_nettype none

`include "mem_axi_params.svh"

module axi_read_master
    import mem_axi_pkg::*;
(
    input  wire     clk,
    input  wire     reset_i,

    // Instruction client
    input  wire     inst_rd_req_i,
    input  wire     addr_t inst_rd_addr_i,
    output logic    inst_rd_rdy_o,
    output logic    inst_ret_valid_o,
    output line_t   inst_ret_data_o,

    // Data client
    input  wire     data_rd_req_i,
    input  wire     addr_t data_rd_addr_i,
    output logic    data_rd_rdy_o,
    output logic    data_ret_valid_o,
    output line_t   data_ret_data_o,

    // AR channel
    output axi_id_t arid_o,
    output addr_t   araddr_o,
    output logic [7:0] arlen_o,
    output logic [2:0] arsize_o,
    output logic [1:0] arburst_o,
    output logic    arvalid_o,
    input  wire     arready_i,

    // R channel
    input  wire     axi_id_t rid_i,
    input  wire     line_t rdata_i,
    input  wire     rlast_i,
    input  wire     rvalid_i,
    output logic    rready_o
);

    rd_ar_state_e ar_state;
    logic         inst_pend;    // Instruction read in flight
    logic         data_pend;    // Data read in flight
    logic         inst_take;
    logic         data_take;
    logic         r_done;
    logic         r_inst;
    logic         r_data;

    // Data client wins a tie, so inst sees no ready while data asks
    assign data_rd_rdy_o = (ar_state == AR_IDLE) && !data_pend;
    assign inst_rd_rdy_o = (ar_state == AR_IDLE) && !inst_pend
                           && !(data_rd_req_i && !data_pend);
    assign data_take     = data_rd_req_i && data_rd_rdy_o;
    assign inst_take     = inst_rd_req_i && inst_rd_rdy_o;

    assign arvalid_o = (ar_state == AR_SEND);
    assign arlen_o   = 8'd0;                        // Single beat
    assign arsize_o  = 3'(`MEM_AXI_SIZE_LINE);
    assign arburst_o = 2'(`MEM_AXI_BURST_INCR);

    // Accept R whenever anything is outstanding
    assign rready_o = inst_pend || data_pend;
    assign r_done   = rvalid_i && rready_o && rlast_i;
    assign r_inst   = r_done && (rid_i == axi_id_t'(`MEM_AXI_INST_ID));
    assign r_data   = r_done && (rid_i == axi_id_t'(`MEM_AXI_DATA_ID));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ar_state <= AR_IDLE;
        end else begin
            case (ar_state)
                AR_IDLE: begin
                    if (data_take || inst_take) begin
                        ar_state <= AR_SEND;
                    end
                end
                AR_SEND: begin
                    if (arready_i) begin
                        ar_state <= AR_IDLE;
                    end
                end
                default: ar_state <= AR_IDLE;
            endcase
        end
    end

    // AR payload, held until arready since no new take while AR_SEND
    always_ff @(posedge clk) begin
        if (data_take) begin
            araddr_o <= data_rd_addr_i;
            arid_o   <= axi_id_t'(`MEM_AXI_DATA_ID);
        end else if (inst_take) begin
            araddr_o <= inst_rd_addr_i;
            arid_o   <= axi_id_t'(`MEM_AXI_INST_ID);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_pend <= 1'b0;
            data_pend <= 1'b0;
        end else begin
            if (inst_take) begin
                inst_pend <= 1'b1;
            end else if (r_inst) begin
                inst_pend <= 1'b0;
            end
            if (data_take) begin
                data_pend <= 1'b1;
            end else if (r_data) begin
                data_pend <= 1'b0;
            end
        end
    end

    // Steer the beat by rid, one cycle later
    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_ret_valid_o <= 1'b0;
            data_ret_valid_o <= 1'b0;
        end else begin
            inst_ret_valid_o <= r_inst;
            data_ret_valid_o <= r_data;
        end
    end

    always_ff @(posedge clk) begin
        if (r_inst) inst_ret_data_o <= rdata_i;
        if (r_data) data_ret_data_o <= rdata_i;
    end

endmodule

`default_nettype wire

// File: source/axi_write_master.sv
`default_nettype none

`include "mem_axi_params.svh"

module axi_write_master
    import mem_axi_pkg::*;
(
    input  wire     clk,
    input  wire     reset_i,

    // Data cache write client
    input  wire     data_wr_req_i,
    input  wire     addr_t data_wr_addr_i,
    input  wire     line_t data_wr_data_i,
    input  wire     strb_t data_wr_strb_i,
    output logic    data_wr_rdy_o,
    output logic    data_wr_done_o,

    // AW channel
    output axi_id_t awid_o,
    output addr_t   awaddr_o,
    output logic [7:0] awlen_o,
    output logic [2:0] awsize_o,
    output logic [1:0] awburst_o,
    output logic    awvalid_o,
    input  wire     awready_i,

    // W channel
    output line_t   wdata_o,
    output strb_t   wstrb_o,
    output logic    wlast_o,
    output logic    wvalid_o,
    input  wire     wready_i,

    // B channel
    input  wire     axi_id_t bid_i,     // Only the bound checker looks at it
    input  wire     bvalid_i,
    output logic    bready_o
);

    wr_state_e wr_state;
    logic      aw_pend;     // AW not yet taken
    logic      w_pend;      // W not yet taken
    logic      wr_take;
    logic      aw_left;
    logic      w_left;

    assign data_wr_rdy_o = (wr_state == WR_IDLE);
    assign wr_take       = data_wr_req_i && data_wr_rdy_o;

    // Still waiting after this cycle
    assign aw_left = aw_pend && !awready_i;
    assign w_left  = w_pend && !wready_i;

    assign awvalid_o = aw_pend;
    assign wvalid_o  = w_pend;
    assign wlast_o   = w_pend;                      // Every beat is the last
    assign bready_o  = (wr_state == WR_RESP);

    assign awid_o    = axi_id_t'(`MEM_AXI_DATA_ID);
    assign awlen_o   = 8'd0;
    assign awsize_o  = 3'(`MEM_AXI_SIZE_LINE);
    assign awburst_o = 2'(`MEM_AXI_BURST_INCR);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_state       <= WR_IDLE;
            aw_pend        <= 1'b0;
            w_pend         <= 1'b0;
            data_wr_done_o <= 1'b0;
        end else begin
            data_wr_done_o <= 1'b0;
            case (wr_state)
                WR_IDLE: begin
                    if (wr_take) begin
                        aw_pend  <= 1'b1;
                        w_pend   <= 1'b1;
                        wr_state <= WR_SEND;
                    end
                end
                WR_SEND: begin
                    // AW and W may be taken in either order
                    aw_pend <= aw_left;
                    w_pend  <= w_left;
                    if (!aw_left && !w_left) begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (bvalid_i) begin
                        data_wr_done_o <= 1'b1;
                        wr_state       <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // Write payload, captured once per write
    always_ff @(posedge clk) begin
        if (wr_take) begin
            awaddr_o <= data_wr_addr_i;
            wdata_o  <= data_wr_data_i;
            wstrb_o  <= data_wr_strb_i;
        end
    end

endmodule

`default_nettype wire

// File: source/mem_axi_bridge.sv
`default_nettype none

`include "mem_axi_params.svh"

module mem_axi_bridge
    import mem_axi_pkg::*;
(
    input  wire     clk,
    input  wire     reset_i,

    // Instruction cache read
    input  wire     inst_rd_req_i,
    input  wire     addr_t inst_rd_addr_i,
    output logic    inst_rd_rdy_o,
    output logic    inst_ret_valid_o,
    output line_t   inst_ret_data_o,

    // Data cache read
    input  wire     data_rd_req_i,
    input  wire     addr_t data_rd_addr_i,
    output logic    data_rd_rdy_o,
    output logic    data_ret_valid_o,
    output line_t   data_ret_data_o,

    // Data cache write
    input  wire     data_wr_req_i,
    input  wire     addr_t data_wr_addr_i,
    input  wire     line_t data_wr_data_i,
    input  wire     strb_t data_wr_strb_i,
    output logic    data_wr_rdy_o,
    output logic    data_wr_done_o,

    // AXI read
    output axi_id_t arid_o,
    output addr_t   araddr_o,
    output logic [7:0] arlen_o,
    output logic [2:0] arsize_o,
    output logic [1:0] arburst_o,
    output logic    arvalid_o,
    input  wire     arready_i,
    input  wire     axi_id_t rid_i,
    input  wire     line_t rdata_i,
    input  wire     rlast_i,
    input  wire     rvalid_i,
    output logic    rready_o,

    // AXI write
    output axi_id_t awid_o,
    output addr_t   awaddr_o,
    output logic [7:0] awlen_o,
    output logic [2:0] awsize_o,
    output logic [1:0] awburst_o,
    output logic    awvalid_o,
    input  wire     awready_i,
    output line_t   wdata_o,
    output strb_t   wstrb_o,
    output logic    wlast_o,
    output logic    wvalid_o,
    input  wire     wready_i,
    input  wire     axi_id_t bid_i,
    input  wire     bvalid_i,
    output logic    bready_o
);

    // Both refill clients share AR and R
    axi_read_master i_axi_read_master (
        .clk              (clk),
        .reset_i          (reset_i),
        .inst_rd_req_i    (inst_rd_req_i),
        .inst_rd_addr_i   (inst_rd_addr_i),
        .inst_rd_rdy_o    (inst_rd_rdy_o),
        .inst_ret_valid_o (inst_ret_valid_o),
        .inst_ret_data_o  (inst_ret_data_o),
        .data_rd_req_i    (data_rd_req_i),
        .data_rd_addr_i   (data_rd_addr_i),
        .data_rd_rdy_o    (data_rd_rdy_o),
        .data_ret_valid_o (data_ret_valid_o),
        .data_ret_data_o  (data_ret_data_o),
        .arid_o           (arid_o),
        .araddr_o         (araddr_o),
        .arlen_o          (arlen_o),
        .arsize_o         (arsize_o),
        .arburst_o        (arburst_o),
        .arvalid_o        (arvalid_o),
        .arready_i        (arready_i),
        .rid_i            (rid_i),
        .rdata_i          (rdata_i),
        .rlast_i          (rlast_i),
        .rvalid_i         (rvalid_i),
        .rready_o         (rready_o)
    );

    // Data cache write-back
    axi_write_master i_axi_write_master (
        .clk            (clk),
        .reset_i        (reset_i),
        .data_wr_req_i  (data_wr_req_i),
        .data_wr_addr_i (data_wr_addr_i),
        .data_wr_data_i (data_wr_data_i),
        .data_wr_strb_i (data_wr_strb_i),
        .data_wr_rdy_o  (data_wr_rdy_o),
        .data_wr_done_o (data_wr_done_o),
        .awid_o         (awid_o),
        .awaddr_o       (awaddr_o),
        .awlen_o        (awlen_o),
        .awsize_o       (awsize_o),
        .awburst_o      (awburst_o),
        .awvalid_o      (awvalid_o),
        .awready_i      (awready_i),
        .wdata_o        (wdata_o),
        .wstrb_o        (wstrb_o),
        .wlast_o        (wlast_o),
        .wvalid_o       (wvalid_o),
        .wready_i       (wready_i),
        .bid_i          (bid_i),
        .bvalid_i       (bvalid_i),
        .bready_o       (bready_o)
    );

endmodule

`default_nettype wire

// File: source/mem_axi_pkg.sv
`default_nettype none

`include "mem_axi_params.svh"

package mem_axi_pkg;

    // Meaningful widths of the bridge
    typedef logic [`MEM_AXI_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`MEM_AXI_LINE_WIDTH-1:0] line_t;
    typedef logic [`MEM_AXI_STRB_WIDTH-1:0] strb_t;
    typedef logic [`MEM_AXI_ID_WIDTH-1:0]   axi_id_t;

    // AR channel
    typedef enum logic {
        AR_IDLE,    // Nothing on AR
        AR_SEND     // Address offered, waiting for arready
    } rd_ar_state_e;

    // Write path
    typedef enum logic [1:0] {
        WR_IDLE,    // Free for a new write
        WR_SEND,    // AW and/or W not yet taken
        WR_RESP     // Waiting for B
    } wr_state_e;

endpackage

`default_nettype wire

// File: testbench/mem_axi_bridge_checker.sv
`default_nettype none

`include "mem_axi_params.svh"

module mem_axi_bridge_checker
    import mem_axi_pkg::*;
(
    input wire          clk,
    input wire          reset_i,
    input wire          arvalid_o,
    input wire          arready_i,
    input wire addr_t   araddr_o,
    input wire axi_id_t arid_o,
    input wire          awvalid_o,
    input wire          awready_i,
    input wire addr_t   awaddr_o,
    input wire          wvalid_o,
    input wire          wready_i,
    input wire          bvalid_i,
    input wire axi_id_t bid_i
);

    // AR held with a stable payload while the slave stalls
    ar_stable: assert property (@(posedge clk) disable iff (reset_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arid_o))
        else $error("arvalid dropped or AR payload changed before arready");

    aw_stable: assert property (@(posedge clk) disable iff (reset_i)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
        else $error("awvalid dropped or awaddr changed before awready");

    w_stable: assert property (@(posedge clk) disable iff (reset_i)
        wvalid_o && !wready_i |=> wvalid_o)
        else $error("wvalid dropped before wready");

    b_id: assert property (@(posedge clk) disable iff (reset_i)
        bvalid_i |-> bid_i == axi_id_t'(`MEM_AXI_DATA_ID))
        else $error("B response carries an unexpected bid");

endmodule

bind mem_axi_bridge mem_axi_bridge_checker i_mem_axi_bridge_checker (.*);

`default_nettype wire

// File: testbench/mem_axi_bridge_tb.sv
`default_nettype none

`include "mem_axi_params.svh"

module mem_axi_bridge_tb
    import mem_axi_pkg::*;
();

    localparam int MAX_CYCLES = 2000;   // Tests need well under 600

    logic clk;
    logic reset_i;
    logic inst_rd_req_i, inst_rd_rdy_o, inst_ret_valid_o;
    logic data_rd_req_i, data_rd_rdy_o, data_ret_valid_o;
    logic data_wr_req_i, data_wr_rdy_o, data_wr_done_o;
    addr_t inst_rd_addr_i, data_rd_addr_i, data_wr_addr_i, araddr_o, awaddr_o;
    line_t inst_ret_data_o, data_ret_data_o, data_wr_data_i, rdata_i, wdata_o;
    strb_t data_wr_strb_i, wstrb_o;
    axi_id_t arid_o, rid_i, awid_o, bid_i;
    logic [7:0] arlen_o, awlen_o;
    logic [2:0] arsize_o, awsize_o;
    logic [1:0] arburst_o, awburst_o;
    logic arvalid_o, arready_i, rlast_i, rvalid_i, rready_o;
    logic awvalid_o, awready_i, wlast_o, wvalid_o, wready_i, bvalid_i, bready_o;

    // Slave model state
    line_t   mem [64];
    line_t   ref_mem [64];          // Expected memory contents
    axi_id_t r_id_q [$];
    line_t   r_data_q [$];
    addr_t   aw_q [$];
    line_t   w_data_q [$];
    strb_t   w_strb_q [$];
    logic    rev_mode;              // Serve the next pair newest first
    axi_id_t last_arid;
    logic [7:0] last_arlen;
    logic [2:0] last_arsize;
    logic [1:0] last_arburst;
    logic    last_wlast;
    line_t   last_wdata;
    strb_t   last_wstrb;
    axi_id_t last_awid;
    addr_t   last_awaddr;
    logic [7:0] last_awlen;
    logic [2:0] last_awsize;
    logic [1:0] last_awburst;
    int      cycles;
    int      errors;

    mem_axi_bridge i_mem_axi_bridge (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    function automatic line_t init_line(int idx);
        line_t l;
        for (int b = 0; b < 16; b++) l[b*8 +: 8] = 8'(idx);
        return l;
    endfunction

    function automatic line_t merge_line(line_t old, line_t nw, strb_t s);
        line_t l;
        l = old;
        for (int b = 0; b < 16; b++) begin
            if (s[b]) l[b*8 +: 8] = nw[b*8 +: 8];
        end
        return l;
    endfunction

    task automatic check(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic slave_delay();
        repeat ($urandom_range(3)) @(posedge clk);
    endtask

    // AR channel of the slave; data is taken from memory at acceptance
    initial begin
        arready_i = 1'b0;
        forever begin
            @(posedge clk);
            if (arvalid_o) begin
                slave_delay();
                arready_i <= 1'b1;
                @(posedge clk);
                last_arid    = arid_o;
                last_arlen   = arlen_o;
                last_arsize  = arsize_o;
                last_arburst = arburst_o;
                r_id_q.push_back(arid_o);
                r_data_q.push_back(mem[araddr_o[9:4]]);
                arready_i <= 1'b0;
            end
        end
    end

    // R channel
    initial begin
        axi_id_t id;
        line_t   d;
        rvalid_i = 1'b0;
        rlast_i  = 1'b0;
        rid_i    = '0;
        rdata_i  = '0;
        forever begin
            @(posedge clk);
            if (r_id_q.size() > 0 && (!rev_mode || r_id_q.size() >= 2)) begin
                if (rev_mode) begin
                    id = r_id_q.pop_back();
                    d  = r_data_q.pop_back();
                    rev_mode = 1'b0;    // Older beat follows in order
                end else begin
                    id = r_id_q.pop_front();
                    d  = r_data_q.pop_front();
                end
                slave_delay();
                rvalid_i <= 1'b1;
                rlast_i  <= 1'b1;
                rid_i    <= id;
                rdata_i  <= d;
                do @(posedge clk); while (!rready_o);
                rvalid_i <= 1'b0;
                rlast_i  <= 1'b0;
            end
        end
    end

    initial begin
        awready_i = 1'b0;
        forever begin
            @(posedge clk);
            if (awvalid_o) begin
                slave_delay();
                awready_i <= 1'b1;
                @(posedge clk);
                last_awid    = awid_o;
                last_awaddr  = awaddr_o;
                last_awlen   = awlen_o;
                last_awsize  = awsize_o;
                last_awburst = awburst_o;
                aw_q.push_back(awaddr_o);
                awready_i <= 1'b0;
            end
        end
    end

    initial begin
        wready_i = 1'b0;
        forever begin
            @(posedge clk);
            if (wvalid_o) begin
                slave_delay();
                wready_i <= 1'b1;
                @(posedge clk);
                last_wlast = wlast_o;
                last_wdata = wdata_o;
                last_wstrb = wstrb_o;
                w_data_q.push_back(wdata_o);
                w_strb_q.push_back(wstrb_o);
                wready_i <= 1'b0;
            end
        end
    end

    // B channel, memory updated once both halves arrived
    initial begin
        addr_t a;
        bvalid_i = 1'b0;
        bid_i    = '0;
        for (int i = 0; i < 64; i++) mem[i] = init_line(i);
        forever begin
            @(posedge clk);
            if (aw_q.size() > 0 && w_data_q.size() > 0) begin
                a = aw_q.pop_front();
                mem[a[9:4]] = merge_line(mem[a[9:4]], w_data_q.pop_front(),
                                         w_strb_q.pop_front());
                slave_delay();
                bvalid_i <= 1'b1;
                bid_i    <= axi_id_t'(`MEM_AXI_DATA_ID);
                do @(posedge clk); while (!bready_o);
                bvalid_i <= 1'b0;
            end
        end
    end

    task automatic read_line(input logic is_inst, input addr_t a, output line_t d);
        @(posedge clk);
        if (is_inst) begin
            inst_rd_req_i  <= 1'b1;
            inst_rd_addr_i <= a;
            do @(posedge clk); while (!inst_rd_rdy_o);
            inst_rd_req_i <= 1'b0;
            do @(posedge clk); while (!inst_ret_valid_o);
            d = inst_ret_data_o;
        end else begin
            data_rd_req_i  <= 1'b1;
            data_rd_addr_i <= a;
            do @(posedge clk); while (!data_rd_rdy_o);
            data_rd_req_i <= 1'b0;
            do @(posedge clk); while (!data_ret_valid_o);
            d = data_ret_data_o;
        end
    endtask

    task automatic write_line(addr_t a, line_t d, strb_t s);
        @(posedge clk);
        data_wr_req_i  <= 1'b1;
        data_wr_addr_i <= a;
        data_wr_data_i <= d;
        data_wr_strb_i <= s;
        do @(posedge clk); while (!data_wr_rdy_o);
        data_wr_req_i <= 1'b0;
        do @(posedge clk); while (!data_wr_done_o);
        ref_mem[a[9:4]] = merge_line(ref_mem[a[9:4]], d, s);
    endtask

    task automatic reset_outputs();
        @(posedge clk);
        check("arvalid_o", 128'(arvalid_o), 128'h0);
        check("awvalid_o", 128'(awvalid_o), 128'h0);
        check("wvalid_o", 128'(wvalid_o), 128'h0);
        check("rready_o", 128'(rready_o), 128'h0);
        check("bready_o", 128'(bready_o), 128'h0);
        check("inst_ret_valid_o", 128'(inst_ret_valid_o), 128'h0);
        check("data_ret_valid_o", 128'(data_ret_valid_o), 128'h0);
        check("data_wr_done_o", 128'(data_wr_done_o), 128'h0);
        check("inst_rd_rdy_o", 128'(inst_rd_rdy_o), 128'h1);
        check("data_rd_rdy_o", 128'(data_rd_rdy_o), 128'h1);
        check("data_wr_rdy_o", 128'(data_wr_rdy_o), 128'h1);
    endtask

    task automatic inst_read();
        line_t d;
        read_line(1'b1, 32'h0000_0150, d);
        check("arid_o", 128'(last_arid), 128'(`MEM_AXI_INST_ID));
        check("arlen_o", 128'(last_arlen), 128'h0);
        check("arsize_o", 128'(last_arsize), 128'(`MEM_AXI_SIZE_LINE));
        check("arburst_o", 128'(last_arburst), 128'(`MEM_AXI_BURST_INCR));
        check("inst_ret_data_o", d, ref_mem[21]);
    endtask

    task automatic dual_read();
        rev_mode = 1'b1;
        @(posedge clk);
        data_rd_req_i  <= 1'b1;
        data_rd_addr_i <= 32'h0000_0230;
        inst_rd_req_i  <= 1'b1;
        inst_rd_addr_i <= 32'h0000_03f0;
        @(posedge clk);
        check("data_rd_rdy_o", 128'(data_rd_rdy_o), 128'h1);
        check("inst_rd_rdy_o", 128'(inst_rd_rdy_o), 128'h0);
        data_rd_req_i <= 1'b0;
        @(posedge clk);
        check("arvalid_o", 128'(arvalid_o), 128'h1);
        check("arid_o", 128'(arid_o), 128'(`MEM_AXI_DATA_ID));
        do @(posedge clk); while (!inst_rd_rdy_o);
        inst_rd_req_i <= 1'b0;
        fork
            begin
                do @(posedge clk); while (!data_ret_valid_o);
                check("data_ret_data_o", data_ret_data_o, ref_mem[35]);
            end
            begin
                do @(posedge clk); while (!inst_ret_valid_o);
                check("inst_ret_data_o", inst_ret_data_o, ref_mem[63]);
            end
        join
    endtask

    task automatic partial_write();
        line_t d;
        line_t nw;
        nw = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
        write_line(32'h0000_0080, nw, 16'h0ff0);
        check("awid_o", 128'(last_awid), 128'(`MEM_AXI_DATA_ID));
        check("awaddr_o", 128'(last_awaddr), 128'h80);
        check("awlen_o", 128'(last_awlen), 128'h0);
        check("awsize_o", 128'(last_awsize), 128'(`MEM_AXI_SIZE_LINE));
        check("awburst_o", 128'(last_awburst), 128'(`MEM_AXI_BURST_INCR));
        check("wdata_o", last_wdata, nw);
        check("wstrb_o", 128'(last_wstrb), 128'h0ff0);
        check("wlast_o", 128'(last_wlast), 128'h1);
        read_line(1'b0, 32'h0000_0080, d);
        check("data_ret_data_o", d, merge_line(init_line(8), nw, 16'h0ff0));
    endtask

    task automatic random_mix();
        line_t d;
        addr_t a;
        int    kind;
        for (int i = 0; i < 20; i++) begin
            kind = int'($urandom_range(2));
            a    = {22'h0, 6'($urandom_range(63)), 4'h0};
            if (kind == 2) begin
                write_line(a, {$urandom(), $urandom(), $urandom(), $urandom()},
                           16'($urandom()));
            end else begin
                read_line(kind == 0, a, d);
                check(kind == 0 ? "inst_ret_data_o" : "data_ret_data_o", d,
                      ref_mem[a[9:4]]);
            end
        end
    endtask

    initial begin
        void'($urandom(12));
        cycles         = 0;
        errors         = 0;
        rev_mode       = 1'b0;
        reset_i        = 1'b1;
        inst_rd_req_i  = 1'b0;
        inst_rd_addr_i = '0;
        data_rd_req_i  = 1'b0;
        data_rd_addr_i = '0;
        data_wr_req_i  = 1'b0;
        data_wr_addr_i = '0;
        data_wr_data_i = '0;
        data_wr_strb_i = '0;
        for (int i = 0; i < 64; i++) ref_mem[i] = init_line(i);
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        reset_outputs();
        inst_read();
        dual_read();
        partial_write();
        random_mix();
        repeat (5) @(posedge clk);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
